// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the trace encoder testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module trdb_tb -f trdb.f \
    --Mdir obj_dir -o trdb_sim

out="$(./obj_dir/trdb_sim)"
echo "$out"

if echo "$out" | grep -qx "TB PASSED"; then
    exit 0
fi
exit 1

// ==== test/trdb_tb.sv ====
// testbench for the branch trace encoder, reference frame model with frame checks
`timescale 1ns/1ps

module trdb_tb;

    localparam int WAIT_LIMIT = 200;  // cycles per wait loop

    logic                  clk;
    logic                  reset;
    logic                  cfg_req;
    logic [1:0]            cfg_addr;
    logic [7:0]            cfg_wdata;
    logic                  cfg_ack;
    trdb_pkg::trdb_instr_t instr;
    logic                  instr_ready;
    logic                  frame_valid;
    trdb_pkg::trdb_frame_t frame;
    logic                  frame_ready;

    int seed = 55370;
    int errors = 0;
    int err_mark = 0;
    int checks = 0;
    int tests = 0;
    int hold_cnt = 0;     // forced ready-low cycles
    logic bp_mode = 1'b0; // random ready
    logic stall_seen = 1'b0;

    // reference model state
    trdb_pkg::trdb_frame_t         exp_q[$];
    logic [trdb_pkg::PAYLOAD_LEN-1:0] acc;  // payload under construction
    int                            acc_n;
    logic [trdb_pkg::BMAP_LEN-1:0] m_map;
    int                            m_cnt;
    logic [31:0]                   m_last;
    logic                          m_en, m_mode, m_pending;
    logic                          m_delta, m_full, m_impl, m_sijump;
    logic [31:0]                   pc;
    trdb_pkg::trdb_instr_t         tr;

    // captured at the transfer edge, compared half a cycle later
    logic                  xfer_q, stray_q;
    trdb_pkg::trdb_frame_t got_q, want_q;

    trdb_top #(
        .FIFO_DEPTH (trdb_pkg::FIFO_DEPTH)
    ) UUT (
        .clk_i         (clk),
        .reset_i       (reset),
        .cfg_req_i     (cfg_req),
        .cfg_addr_i    (cfg_addr),
        .cfg_wdata_i   (cfg_wdata),
        .cfg_ack_o     (cfg_ack),
        .instr_i       (instr),
        .instr_ready_o (instr_ready),
        .frame_valid_o (frame_valid),
        .frame_o       (frame),
        .frame_ready_i (frame_ready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        if (reset) begin
            xfer_q  <= 1'b0;
            stray_q <= 1'b0;
        end else begin
            xfer_q  <= frame_valid && frame_ready;
            stray_q <= 1'b0;
            if (frame_valid && frame_ready) begin
                got_q <= frame;
                checks++;
                if (exp_q.size() == 0) stray_q <= 1'b1;  // nothing owed
                else want_q <= exp_q.pop_front();
            end
        end
    end

    // full queue plus a held packet must stop the instruction port
    always @(posedge clk) begin
        if (!reset && !UUT.pkt_ready && !instr_ready) stall_seen <= 1'b1;
    end

    frame_matches: assert property (
        @(negedge clk) disable iff (reset)
        xfer_q && !stray_q |-> got_q == want_q
    ) else begin
        errors++;
        $display("** Error frame_o: got %h, expected %h", got_q, want_q);
    end

    no_stray_frame: assert property (
        @(negedge clk) disable iff (reset)
        !stray_q
    ) else begin
        errors++;
        $display("a frame came out while no frame was expected");
    end

    initial begin
        frame_ready = 1'b1;
        forever begin
            @(negedge clk);
            if (hold_cnt > 0) begin
                frame_ready = 1'b0;
                hold_cnt--;
            end else if (bp_mode) begin
                frame_ready = coin() | coin();  // ready about 3 cycles in 4
            end else begin
                frame_ready = 1'b1;
            end
        end
    end

    function automatic logic coin();
        logic [31:0] r;
        r = $random(seed);
        return r[0];
    endfunction

    function automatic logic [31:0] rand_addr();
        logic [31:0] a;
        a = $random(seed);
        a[1:0] = 2'b00;  // word aligned
        return a;
    endfunction

    function automatic trdb_pkg::trdb_instr_t make_instr(input logic [31:0] addr,
            input logic br, input logic tk, input logic upd);
        trdb_pkg::trdb_instr_t in;
        in           = '0;
        in.iaddr     = addr;
        in.is_branch = br;
        in.taken     = br && tk;
        in.updiscon  = upd;
        in.priv      = 2'b11;  // machine mode
        return in;
    endfunction

    task automatic give_up(input string what);
        $display("timeout while waiting for %s", what);
        $display("TB FAILED");
        $finish;
    endtask

    // appends a field msb first behind the fields already placed
    task automatic field(input logic [63:0] v, input int n);
        for (int i = n - 1; i >= 0; i--) begin
            acc[trdb_pkg::PAYLOAD_LEN - 1 - acc_n] = v[i];
            acc_n++;
        end
    endtask

    task automatic queue_frame();
        trdb_pkg::trdb_frame_t f;
        f.packet.payload        = acc;
        f.packet.payload_length = trdb_pkg::PLEN_LEN'((acc_n + 7) / 8);  // whole bytes
        f.header = {acc[trdb_pkg::PAYLOAD_LEN-1 -: 2], 1'b0, f.packet.payload_length};
        exp_q.push_back(f);
        acc   = '0;
        acc_n = 0;
    endtask

    task automatic model_support();
        logic [2:0] iopt;
        if (m_delta) iopt = 3'd0;
        else if (m_full) iopt = 3'd1;
        else if (m_impl) iopt = 3'd2;
        else if (m_sijump) iopt = 3'd3;
        else iopt = 3'd1;  // no mode picked, full addresses
        field(trdb_pkg::F_SYNC, 2);
        field(trdb_pkg::SF_SUPPORT, 2);
        field(1, 1);       // ienable
        field(m_mode, 1);
        field(0, 2);       // qual_status
        field(iopt, 3);
        queue_frame();
        m_pending = 1'b1;
        m_map     = '0;
        m_cnt     = 0;
    endtask

    task automatic model_instr(input trdb_pkg::trdb_instr_t in);
        logic [trdb_pkg::BMAP_LEN-1:0] map_n;
        int                            cnt_n;
        logic [31:0]                   diff;
        logic                          nb;
        logic                          sent;
        logic                          report;
        if (m_en) begin
            map_n = m_map;
            cnt_n = m_cnt;
            if (in.is_branch) begin
                map_n = {m_map[trdb_pkg::BMAP_LEN-2:0], ~in.taken};  // 1 = not taken
                cnt_n++;
            end
            nb     = !(in.is_branch && in.taken);
            diff   = m_delta ? in.iaddr - m_last : in.iaddr;
            sent   = 1'b1;
            report = 1'b1;
            if (m_pending) begin
                field(trdb_pkg::F_SYNC, 2);
                field(trdb_pkg::SF_START, 2);
                field(nb, 1);
                field(in.priv, trdb_pkg::PRIV_LEN);
                field(in.iaddr, trdb_pkg::XLEN);
            end else if (in.exception || in.interrupt) begin
                field(trdb_pkg::F_SYNC, 2);
                field(trdb_pkg::SF_TRAP, 2);
                field(nb, 1);
                field(in.priv, trdb_pkg::PRIV_LEN);
                field(in.cause, trdb_pkg::CAUSE_LEN);
                field(in.interrupt, 1);
                field(0, 1);  // thaddr
                field(in.iaddr, trdb_pkg::XLEN);
                field(in.tval, trdb_pkg::XLEN);
            end else if (in.updiscon && cnt_n != 0) begin
                field(trdb_pkg::F_DIFF_DELTA, 2);
                field(cnt_n, trdb_pkg::BCNT_LEN);
                field(map_n, trdb_pkg::BMAP_LEN);
                field(diff, trdb_pkg::XLEN);
                field({3{diff[31]}}, 3);  // notify, updiscon, irreport
            end else if (in.updiscon) begin
                field(trdb_pkg::F_ADDR_ONLY, 2);
                field(in.iaddr, trdb_pkg::XLEN);
                field({3{in.iaddr[31]}}, 3);
            end else if (cnt_n == trdb_pkg::BMAP_LEN) begin
                field(trdb_pkg::F_DIFF_DELTA, 2);
                field(cnt_n, trdb_pkg::BCNT_LEN);
                field(map_n, trdb_pkg::BMAP_LEN);
                report = 1'b0;  // full map carries no address
            end else begin
                sent   = 1'b0;
                report = 1'b0;
            end
            if (sent) begin
                queue_frame();
                m_map     = '0;
                m_cnt     = 0;
                m_pending = 1'b0;
            end else begin
                m_map = map_n;
                m_cnt = cnt_n;
            end
            if (report) m_last = in.iaddr;
        end
    endtask

    // four-phase write, ack expected exactly one cycle behind req both ways
    task automatic cfg_write(input logic [1:0] addr, input logic [7:0] data);
        int t;
        if (addr == 2'd0) begin
            m_mode = data[1];
            if (data[0] && !m_en) model_support();  // enable edge
            m_en = data[0];
        end else if (addr == 2'd1) begin
            m_delta  = data[0];
            m_full   = data[1];
            m_impl   = data[2];
            m_sijump = data[3];
        end
        cfg_addr  = addr;
        cfg_wdata = data;
        cfg_req   = 1'b1;
        t = 0;
        do begin
            if (t == WAIT_LIMIT) give_up("cfg_ack_o to rise");
            @(negedge clk);
            t++;
        end while (!cfg_ack);
        assert (t == 1) else begin
            errors++;
            $display("cfg_ack_o rose %0d cycles after cfg_req_i instead of 1", t);
        end
        cfg_req = 1'b0;
        t = 0;
        do begin
            if (t == WAIT_LIMIT) give_up("cfg_ack_o to fall");
            @(negedge clk);
            t++;
        end while (cfg_ack);
        assert (t == 1) else begin
            errors++;
            $display("cfg_ack_o fell %0d cycles after cfg_req_i instead of 1", t);
        end
    endtask

    task automatic send_instr(input trdb_pkg::trdb_instr_t in);
        int t;
        model_instr(in);
        instr       = in;
        instr.valid = 1'b1;
        t = 0;
        while (!instr_ready) begin
            if (t == WAIT_LIMIT) give_up("instr_ready_o");
            @(negedge clk);
            t++;
        end
        @(negedge clk);  // taken at the edge in between
        instr.valid = 1'b0;
    endtask

    task automatic end_test(input string name);
        int t;
        t = 0;
        while (exp_q.size() != 0) begin
            if (t == 5 * WAIT_LIMIT) give_up({"the frames of test ", name});
            @(negedge clk);
            t++;
        end
        @(negedge clk);  // compare of the last frame
        tests++;
        $display("test %-14s %0d errors", name, errors - err_mark);
        err_mark = errors;
    endtask

    initial begin
        cfg_req   = 1'b0;
        cfg_addr  = 2'd0;
        cfg_wdata = 8'h00;
        instr     = '0;
        acc       = '0;
        acc_n     = 0;
        m_map     = '0;
        m_cnt     = 0;
        m_last    = '0;
        m_en      = 1'b0;
        m_mode    = 1'b0;
        m_pending = 1'b0;
        m_delta   = 1'b0;
        m_full    = 1'b0;
        m_impl    = 1'b0;
        m_sijump  = 1'b0;
        reset     = 1'b1;
        repeat (16) @(negedge clk);
        reset = 1'b0;
        assert (instr_ready && !cfg_ack && !frame_valid) else begin
            errors++;
            $display("DUT outputs not idle after reset");
        end

        cfg_write(2'd1, 8'h08);  // sijump only
        cfg_write(2'd3, 8'hff);  // unmapped, dropped
        cfg_write(2'd0, 8'h01);
        cfg_write(2'd0, 8'h00);
        cfg_write(2'd1, 8'h05);  // delta wins over implicit exception
        end_test("config");

        cfg_write(2'd0, 8'h01);
        pc = rand_addr();
        send_instr(make_instr(pc, 1'b1, 1'b1, 1'b0));  // start on a taken branch
        end_test("enable");

        for (int i = 0; i < trdb_pkg::BMAP_LEN; i++) begin
            pc += 4;
            send_instr(make_instr(pc, 1'b1, coin(), 1'b0));
        end
        end_test("full_map");

        repeat (5) begin
            pc += 4;
            send_instr(make_instr(pc, 1'b1, coin(), 1'b0));
        end
        pc += 4;
        send_instr(make_instr(pc, 1'b0, 1'b0, 1'b1));  // jump after branches
        pc = rand_addr();
        send_instr(make_instr(pc, 1'b0, 1'b0, 1'b1));  // lone jump
        end_test("discontinuity");

        repeat (3) begin
            pc += 4;
            send_instr(make_instr(pc, 1'b1, coin(), 1'b0));
        end
        tr           = make_instr(pc + 4, 1'b0, 1'b0, 1'b0);
        tr.exception = 1'b1;
        tr.cause     = trdb_pkg::CAUSE_LEN'($random(seed));
        tr.tval      = $random(seed);
        send_instr(tr);
        pc           = rand_addr();
        tr           = make_instr(pc, 1'b0, 1'b0, 1'b0);
        tr.interrupt = 1'b1;
        tr.cause     = trdb_pkg::CAUSE_LEN'($random(seed));
        send_instr(tr);
        end_test("trap");

        hold_cnt = 30;
        bp_mode  = 1'b1;
        for (int i = 0; i < 12; i++) begin
            pc = rand_addr();
            send_instr(make_instr(pc, coin(), coin(), 1'b1));
        end
        assert (stall_seen) else begin
            errors++;
            $display("instr_ready_o never fell while the frame FIFO was full");
        end
        end_test("backpressure");
        bp_mode = 1'b0;

        $display("tests %0d, frames checked %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== trdb.f ====
verilog/trdb_pkg.sv
verilog/trdb_config_regs.sv
verilog/trdb_branch_map.sv
verilog/trdb_packet_emitter.sv
verilog/trdb_encapsulator.sv
verilog/trdb_top.sv
test/trdb_tb.sv

// ==== verilog/trdb_branch_map.sv ====
// collects branch outcomes and decides when a trace packet is due
`timescale 1ns/1ps

module trdb_branch_map (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  trdb_pkg::trdb_cfg_t   cfg_i,
    input  trdb_pkg::trdb_instr_t instr_i,
    output logic                  instr_ready_o,
    input  logic                  stall_i,
    output logic                  req_valid_o,
    output trdb_pkg::trdb_req_t   req_o
);

    logic [trdb_pkg::BMAP_LEN-1:0] bmap_q, bmap_n;
    logic [trdb_pkg::BCNT_LEN-1:0] cnt_q, cnt_n;
    logic [trdb_pkg::XLEN-1:0]     last_addr_q;  // last address put in a packet
    logic                          en_q;
    logic                          pending_start_q;
    logic                          en_edge;
    logic                          can_issue;
    logic                          fire;
    logic                          trig;
    logic                          report_addr;
    trdb_pkg::trdb_ioptions_e      ioptions;
    trdb_pkg::trdb_req_t           req_n;

    assign en_edge   = cfg_i.enable && !en_q;
    // emitter must be empty in the cycle a request lands
    assign can_issue = !stall_i && !req_valid_o;
    assign instr_ready_o = can_issue && !en_edge;  // support packet goes first
    assign fire = instr_i.valid && instr_ready_o && cfg_i.enable;

    // newest outcome in bit 0 where 1 means not taken
    always_comb begin
        bmap_n = bmap_q;
        cnt_n  = cnt_q;
        if (instr_i.is_branch) begin
            bmap_n = {bmap_q[trdb_pkg::BMAP_LEN-2:0], ~instr_i.taken};
            cnt_n  = cnt_q + 1'b1;
        end
    end

    always_comb begin
        if (cfg_i.delta_address) begin
            ioptions = trdb_pkg::DELTA_ADDRESS;
        end else if (cfg_i.full_address) begin
            ioptions = trdb_pkg::FULL_ADDRESS;
        end else if (cfg_i.implicit_exception) begin
            ioptions = trdb_pkg::IMPLICIT_EXCEPTION;
        end else if (cfg_i.sijump) begin
            ioptions = trdb_pkg::SIJUMP;
        end else begin
            ioptions = trdb_pkg::FULL_ADDRESS;  // full addresses are sent then
        end
    end

    always_comb begin
        req_n              = '0;
        req_n.branches     = cnt_n;
        req_n.branch_map   = bmap_n;
        req_n.iaddr        = instr_i.iaddr;
        req_n.diff_addr    = cfg_i.delta_address ? instr_i.iaddr - last_addr_q : instr_i.iaddr;
        req_n.cause        = instr_i.cause;
        req_n.tval         = instr_i.tval;
        req_n.interrupt    = instr_i.interrupt;
        req_n.priv         = instr_i.priv;
        req_n.ioptions     = ioptions;
        req_n.branch       = !(instr_i.is_branch && instr_i.taken);
        req_n.encoder_mode = cfg_i.encoder_mode;
        trig        = 1'b0;
        report_addr = 1'b0;
        if (en_edge) begin
            req_n.format    = trdb_pkg::F_SYNC;
            req_n.subformat = trdb_pkg::SF_SUPPORT;
            trig = can_issue;  // waits for a free emitter
        end else if (fire) begin
            trig        = 1'b1;
            report_addr = 1'b1;
            if (pending_start_q) begin
                req_n.format    = trdb_pkg::F_SYNC;
                req_n.subformat = trdb_pkg::SF_START;
            end else if (instr_i.exception || instr_i.interrupt) begin
                req_n.format    = trdb_pkg::F_SYNC;
                req_n.subformat = trdb_pkg::SF_TRAP;
            end else if (instr_i.updiscon && cnt_n != '0) begin
                req_n.format = trdb_pkg::F_DIFF_DELTA;  // map plus address
            end else if (instr_i.updiscon) begin
                req_n.format = trdb_pkg::F_ADDR_ONLY;
            end else if (cnt_n == trdb_pkg::BMAP_LEN) begin
                req_n.format = trdb_pkg::F_DIFF_DELTA;  // full map without address
                report_addr  = 1'b0;
            end else begin
                trig        = 1'b0;
                report_addr = 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            req_valid_o     <= 1'b0;
            en_q            <= 1'b0;
            pending_start_q <= 1'b0;
            bmap_q          <= '0;
            cnt_q           <= '0;
            last_addr_q     <= '0;
        end else begin
            req_valid_o <= trig;  // one-cycle pulse
            if (!en_edge || can_issue) en_q <= cfg_i.enable;
            if (report_addr) last_addr_q <= instr_i.iaddr;
            if (trig) begin
                bmap_q          <= '0;
                cnt_q           <= '0;
                pending_start_q <= en_edge;  // support then start
            end else if (fire) begin
                bmap_q <= bmap_n;
                cnt_q  <= cnt_n;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (trig) req_o <= req_n;
    end

    // a full map is flushed in the cycle it fills
    cnt_in_range: assert property (
        @(posedge clk_i) disable iff (reset_i)
        cnt_q < trdb_pkg::BMAP_LEN
    );

endmodule

// ==== verilog/trdb_config_regs.sv ====
// encoder option registers, written by the host through a four-phase req/ack port
`timescale 1ns/1ps

module trdb_config_regs (
    input  logic                clk_i,
    input  logic                reset_i,
    input  logic                cfg_req_i,
    input  logic [1:0]          cfg_addr_i,
    input  logic [7:0]          cfg_wdata_i,
    output logic                cfg_ack_o,
    output trdb_pkg::trdb_cfg_t cfg_o
);

    logic wr_en;

    // only the first cycle of a request writes since ack blocks the rest
    assign wr_en = cfg_req_i && !cfg_ack_o;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            cfg_ack_o <= 1'b0;
            cfg_o     <= '0;  // encoder disabled
        end else begin
            cfg_ack_o <= cfg_req_i;  // rises and falls one cycle behind req
            if (wr_en) begin
                case (cfg_addr_i)
                    2'd0: begin
                        cfg_o.enable       <= cfg_wdata_i[0];
                        cfg_o.encoder_mode <= cfg_wdata_i[1];
                    end
                    2'd1: begin
                        cfg_o.delta_address      <= cfg_wdata_i[0];
                        cfg_o.full_address       <= cfg_wdata_i[1];
                        cfg_o.implicit_exception <= cfg_wdata_i[2];
                        cfg_o.sijump             <= cfg_wdata_i[3];
                    end
                    default: ;  // acked with nothing behind it
                endcase
            end
        end
    end

    // host keeps req up until it sees ack
    req_held_until_ack: assert property (
        @(posedge clk_i) disable iff (reset_i)
        $fell(cfg_req_i) |-> cfg_ack_o
    );

endmodule

// ==== verilog/trdb_encapsulator.sv ====
// adds the length/format header and queues frames toward the output port
`timescale 1ns/1ps

module trdb_encapsulator #(
    parameter int DEPTH = 4
) (
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  logic                   pkt_valid_i,
    input  trdb_pkg::trdb_packet_t pkt_i,
    output logic                   pkt_ready_o,
    output logic                   frame_valid_o,
    output trdb_pkg::trdb_frame_t  frame_o,
    input  logic                   frame_ready_i
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    trdb_pkg::trdb_frame_t mem [DEPTH];
    trdb_pkg::trdb_frame_t frame_in;
    logic [PTR_W-1:0]      wr_ptr_q, rd_ptr_q;
    logic [CNT_W-1:0]      cnt_q;
    logic                  wr_en, rd_en;

    // format from the payload's leading bits and length in the low bits
    assign frame_in.header = {pkt_i.payload[trdb_pkg::PAYLOAD_LEN-1 -: 2], 1'b0,
                              pkt_i.payload_length};
    assign frame_in.packet = pkt_i;

    assign pkt_ready_o   = (cnt_q != CNT_W'(DEPTH));
    assign frame_valid_o = (cnt_q != '0);
    assign frame_o       = mem[rd_ptr_q];  // head of queue
    assign wr_en = pkt_valid_i && pkt_ready_o;
    assign rd_en = frame_valid_o && frame_ready_i;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            cnt_q    <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (rd_en) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            cnt_q <= cnt_q + CNT_W'(wr_en) - CNT_W'(rd_en);
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_en) mem[wr_ptr_q] <= frame_in;
    end

    // occupancy within depth and in step with the pointer distance
    fifo_no_overflow: assert property (
        @(posedge clk_i) disable iff (reset_i)
        cnt_q <= CNT_W'(DEPTH)
            && (int'(rd_ptr_q) + int'(cnt_q)) % DEPTH == int'(wr_ptr_q)
    );

endmodule

// ==== verilog/trdb_packet_emitter.sv ====
// builds the left-aligned packet payload and its byte length for each format
`timescale 1ns/1ps

module trdb_packet_emitter (
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  logic                   req_valid_i,
    input  trdb_pkg::trdb_req_t    req_i,
    input  logic                   pkt_ready_i,
    output logic                   pkt_valid_o,
    output trdb_pkg::trdb_packet_t pkt_o,
    output logic                   busy_o
);

    localparam int PL = trdb_pkg::PAYLOAD_LEN;
    localparam int XL = trdb_pkg::XLEN;

    // payload widths in bits
    localparam int START_BITS   = 5 + trdb_pkg::PRIV_LEN + XL;
    localparam int TRAP_BITS    = 7 + trdb_pkg::PRIV_LEN + trdb_pkg::CAUSE_LEN + 2 * XL;
    localparam int SUPPORT_BITS = 8 + $bits(trdb_pkg::trdb_ioptions_e);
    localparam int ADDR_BITS    = 5 + XL;
    localparam int F1_FULL_BITS = 2 + trdb_pkg::BCNT_LEN + trdb_pkg::BMAP_LEN;
    localparam int F1_ADDR_BITS = F1_FULL_BITS + XL + 3;

    logic                   notify_f2;
    logic                   notify_f1;
    trdb_pkg::trdb_packet_t pkt_d;

    // notify is the top bit of the address field, updiscon and irreport copy it
    assign notify_f2 = req_i.iaddr[XL-1];
    assign notify_f1 = req_i.diff_addr[XL-1];

    always_comb begin
        pkt_d = '0;
        case (req_i.format)
            trdb_pkg::F_SYNC: begin
                case (req_i.subformat)
                    trdb_pkg::SF_START: begin
                        pkt_d.payload = {trdb_pkg::F_SYNC, trdb_pkg::SF_START, req_i.branch,
                                         req_i.priv, req_i.iaddr, {(PL - START_BITS){1'b0}}};
                        pkt_d.payload_length = trdb_pkg::PLEN_LEN'((START_BITS + 7) / 8);
                    end
                    trdb_pkg::SF_TRAP: begin
                        // thaddr clear, address is the trapping instruction
                        pkt_d.payload = {trdb_pkg::F_SYNC, trdb_pkg::SF_TRAP, req_i.branch,
                                         req_i.priv, req_i.cause, req_i.interrupt, 1'b0,
                                         req_i.iaddr, req_i.tval, {(PL - TRAP_BITS){1'b0}}};
                        pkt_d.payload_length = trdb_pkg::PLEN_LEN'((TRAP_BITS + 7) / 8);
                    end
                    trdb_pkg::SF_SUPPORT: begin
                        // sent only on enable, so ienable is set
                        pkt_d.payload = {trdb_pkg::F_SYNC, trdb_pkg::SF_SUPPORT, 1'b1,
                                         req_i.encoder_mode, 2'b00, req_i.ioptions,
                                         {(PL - SUPPORT_BITS){1'b0}}};
                        pkt_d.payload_length = trdb_pkg::PLEN_LEN'((SUPPORT_BITS + 7) / 8);
                    end
                    default: ;  // context subformat not produced
                endcase
            end
            trdb_pkg::F_ADDR_ONLY: begin
                pkt_d.payload = {trdb_pkg::F_ADDR_ONLY, req_i.iaddr,
                                 {3{notify_f2}}, {(PL - ADDR_BITS){1'b0}}};
                pkt_d.payload_length = trdb_pkg::PLEN_LEN'((ADDR_BITS + 7) / 8);
            end
            trdb_pkg::F_DIFF_DELTA: begin
                if (req_i.branches < trdb_pkg::BMAP_LEN) begin  // map not full, address needed
                    pkt_d.payload = {trdb_pkg::F_DIFF_DELTA, req_i.branches, req_i.branch_map,
                                     req_i.diff_addr, {3{notify_f1}},
                                     {(PL - F1_ADDR_BITS){1'b0}}};
                    pkt_d.payload_length = trdb_pkg::PLEN_LEN'((F1_ADDR_BITS + 7) / 8);
                end else begin
                    pkt_d.payload = {trdb_pkg::F_DIFF_DELTA, req_i.branches, req_i.branch_map,
                                     {(PL - F1_FULL_BITS){1'b0}}};
                    pkt_d.payload_length = trdb_pkg::PLEN_LEN'((F1_FULL_BITS + 7) / 8);
                end
            end
            default: ;  // format 0 not supported
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pkt_valid_o <= 1'b0;
        end else if (req_valid_i) begin
            pkt_valid_o <= 1'b1;
        end else if (pkt_ready_i) begin
            pkt_valid_o <= 1'b0;  // taken by the encapsulator
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_valid_i) pkt_o <= pkt_d;
    end

    assign busy_o = pkt_valid_o && !pkt_ready_i;  // holding a packet

    // branch map must not send while a packet is held
    held_pkt_stable: assert property (
        @(posedge clk_i) disable iff (reset_i)
        pkt_valid_o && !pkt_ready_i |=> pkt_valid_o && $stable(pkt_o)
    );

endmodule

// ==== verilog/trdb_pkg.sv ====
// shared widths, packet format codes and bundled types of the branch trace encoder
package trdb_pkg;

    localparam int XLEN        = 32;   // instruction address width
    localparam int PRIV_LEN    = 2;
    localparam int CAUSE_LEN   = 5;
    localparam int BMAP_LEN    = 31;   // branch map capacity
    localparam int BCNT_LEN    = $clog2(BMAP_LEN + 1);
    localparam int PAYLOAD_LEN = 128;  // widest payload, left aligned
    localparam int PLEN_LEN    = 5;    // payload length in bytes
    localparam int FIFO_DEPTH  = 4;    // default frame queue depth

    // packet format, top two bits of every payload
    typedef enum logic [1:0] {
        F_OPT_EXT    = 2'h0,
        F_DIFF_DELTA = 2'h1,
        F_ADDR_ONLY  = 2'h2,
        F_SYNC       = 2'h3
    } trdb_format_e;

    typedef enum logic [1:0] {
        SF_START   = 2'h0,
        SF_TRAP    = 2'h1,
        SF_CONTEXT = 2'h2,
        SF_SUPPORT = 2'h3
    } trdb_f_sync_subformat_e;

    // highest priority mode first
    typedef enum logic [2:0] {
        DELTA_ADDRESS      = 3'h0,
        FULL_ADDRESS       = 3'h1,
        IMPLICIT_EXCEPTION = 3'h2,
        SIJUMP             = 3'h3,
        IMPLICIT_RETURN    = 3'h4,
        BRANCH_PREDICTION  = 3'h5,
        JUMP_TARGET_CACHE  = 3'h6
    } trdb_ioptions_e;

    typedef struct packed {
        logic                 valid;
        logic [XLEN-1:0]      iaddr;
        logic                 is_branch;
        logic                 taken;
        logic                 exception;
        logic                 interrupt;
        logic [CAUSE_LEN-1:0] cause;
        logic [XLEN-1:0]      tval;
        logic [PRIV_LEN-1:0]  priv;
        logic                 updiscon;  // uninferable discontinuity
    } trdb_instr_t;

    typedef struct packed {
        logic enable;
        logic delta_address;
        logic full_address;
        logic implicit_exception;
        logic sijump;
        logic encoder_mode;  // 0 = branch trace
    } trdb_cfg_t;

    typedef struct packed {
        trdb_format_e           format;
        trdb_f_sync_subformat_e subformat;
        logic [BCNT_LEN-1:0]    branches;
        logic [BMAP_LEN-1:0]    branch_map;
        logic [XLEN-1:0]        iaddr;
        logic [XLEN-1:0]        diff_addr;
        logic [CAUSE_LEN-1:0]   cause;
        logic [XLEN-1:0]        tval;
        logic                   interrupt;
        logic [PRIV_LEN-1:0]    priv;
        trdb_ioptions_e         ioptions;
        logic                   branch;        // not a taken branch
        logic                   encoder_mode;
    } trdb_req_t;

    typedef struct packed {
        logic [PLEN_LEN-1:0]    payload_length;
        logic [PAYLOAD_LEN-1:0] payload;
    } trdb_packet_t;

    typedef struct packed {
        logic [7:0]   header;  // {format, 1'b0, payload_length}
        trdb_packet_t packet;
    } trdb_frame_t;

endpackage

// ==== verilog/trdb_top.sv ====
// branch trace encoder top, config block beside the branch map it steers
`timescale 1ns/1ps

module trdb_top #(
    parameter int FIFO_DEPTH = trdb_pkg::FIFO_DEPTH
) (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  logic                  cfg_req_i,
    input  logic [1:0]            cfg_addr_i,
    input  logic [7:0]            cfg_wdata_i,
    output logic                  cfg_ack_o,
    input  trdb_pkg::trdb_instr_t instr_i,
    output logic                  instr_ready_o,
    output logic                  frame_valid_o,
    output trdb_pkg::trdb_frame_t frame_o,
    input  logic                  frame_ready_i
);

    trdb_pkg::trdb_cfg_t    cfg;
    trdb_pkg::trdb_req_t    req;
    trdb_pkg::trdb_packet_t pkt;
    logic                   req_valid;
    logic                   pkt_valid;
    logic                   pkt_ready;  // low while the queue is full
    logic                   busy;       // emitter holding a packet

    trdb_config_regs i_config_regs (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .cfg_req_i   (cfg_req_i),
        .cfg_addr_i  (cfg_addr_i),
        .cfg_wdata_i (cfg_wdata_i),
        .cfg_ack_o   (cfg_ack_o),
        .cfg_o       (cfg)
    );

    trdb_branch_map i_branch_map (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .cfg_i         (cfg),
        .instr_i       (instr_i),
        .instr_ready_o (instr_ready_o),
        .stall_i       (busy),
        .req_valid_o   (req_valid),
        .req_o         (req)
    );

    trdb_packet_emitter i_packet_emitter (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .req_valid_i (req_valid),
        .req_i       (req),
        .pkt_ready_i (pkt_ready),
        .pkt_valid_o (pkt_valid),
        .pkt_o       (pkt),
        .busy_o      (busy)
    );

    trdb_encapsulator #(
        .DEPTH (FIFO_DEPTH)
    ) i_encapsulator (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .pkt_valid_i   (pkt_valid),
        .pkt_i         (pkt),
        .pkt_ready_o   (pkt_ready),
        .frame_valid_o (frame_valid_o),
        .frame_o       (frame_o),
        .frame_ready_i (frame_ready_i)
    );

endmodule
